// ==== logic/llc_cfg_pkg.sv ====
// Sizing and timing constants of the LLC request/response path
package llc_cfg_pkg;

  // Request and response field widths
  localparam int unsigned AddrWidth = 32;
  localparam int unsigned DataWidth = 32;
  localparam int unsigned IdWidth   = 4;

  // Programmable delay of up to 255 cycles per item
  localparam int unsigned DelayWidth = 8;

  // Entries held by each delay stage
  localparam int unsigned DelayDepth = 8;

  // Requests in flight towards memory before the isolate stage stalls
  localparam int unsigned MaxOutstanding = 15;
  localparam int unsigned CountWidth     = 4;

  // Cycle stamp one bit wider than a programmed delay
  localparam int unsigned StampWidth = 9;

endpackage

// ==== logic/llc_txn_pkg.sv ====
// Request and response payload structs of the LLC path
package llc_txn_pkg;

  import llc_cfg_pkg::*;

  // Single request channel with one beat per transaction
  typedef struct packed {
    logic [AddrWidth-1:0] addr;
    logic                 we;
    logic [DataWidth-1:0] wdata;
    logic [IdWidth-1:0]   id;
  } llc_req_t;

  // Single response channel returned in request order
  typedef struct packed {
    logic [IdWidth-1:0]   id;
    logic [DataWidth-1:0] rdata;
    logic                 err;
  } llc_rsp_t;

endpackage

// ==== logic/llc_delay_stage.sv ====
// In-order FIFO that releases each item a programmable number of cycles after entry
`timescale 1ns/1ns

module llc_delay_stage
  import llc_cfg_pkg::*;
  import llc_txn_pkg::*;
#(
  parameter type payload_t = llc_req_t
) (
  input  logic                  clk_i,
  input  logic                  reset_i,
  input  logic [DelayWidth-1:0] delay_i,
  input  logic                  in_valid_i,
  output logic                  in_ready_o,
  input  payload_t              in_data_i,
  output logic                  out_valid_o,
  input  logic                  out_ready_i,
  output payload_t              out_data_o
);

  logic [$clog2(DelayDepth)-1:0] wr_ptr_q;
  logic [$clog2(DelayDepth)-1:0] rd_ptr_q;
  logic [$clog2(DelayDepth):0]   count_q;
  logic [StampWidth-1:0]         stamp_q;
  payload_t                      data_mem    [DelayDepth];
  logic [StampWidth-1:0]         release_mem [DelayDepth];
  logic [DelayDepth-1:0]         ripe_q;
  logic [DelayDepth-1:0]         passed;
  logic                          push;
  logic                          pop;

  // Entry is due once the stamp counter reaches its release stamp
  for (genvar i = 0; i < DelayDepth; i++) begin : gen_due
    logic [StampWidth-1:0] diff;

    assign diff      = stamp_q - release_mem[i];
    assign passed[i] = ~diff[StampWidth-1];
  end

  assign in_ready_o  = (count_q != DelayDepth);
  assign push        = in_valid_i && in_ready_o;

  // Only the head is offered so the stage stays in order
  assign out_valid_o = (count_q != '0) && (ripe_q[rd_ptr_q] || passed[rd_ptr_q]);
  assign out_data_o  = data_mem[rd_ptr_q];
  assign pop         = out_valid_o && out_ready_i;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
      stamp_q  <= '0;
      ripe_q   <= '0;
    end else begin
      stamp_q <= stamp_q + 1'b1;
      // Latch due entries so a long stall cannot wrap the stamp compare
      ripe_q  <= ripe_q | passed;
      if (push) begin
        ripe_q[wr_ptr_q] <= 1'b0;
        // Pointers wrap by themselves at a power-of-two depth
        wr_ptr_q         <= wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
      if (push && !pop) begin
        count_q <= count_q + 1'b1;
      end else if (!push && pop) begin
        count_q <= count_q - 1'b1;
      end
    end
  end

  // Release stamp lands delay plus one cycles after acceptance
  always_ff @(posedge clk_i) begin
    if (push) begin
      data_mem[wr_ptr_q]    <= in_data_i;
      release_mem[wr_ptr_q] <= stamp_q + delay_i + 1'b1;
    end
  end

  // A full buffer must never take another item
  assert property (@(posedge clk_i) disable iff (reset_i)
    (count_q != '0) && (wr_ptr_q == rd_ptr_q) |-> !push)
    else $error("delay stage accepted a write while full");

  // Held head stays put until the consumer takes it
  assert property (@(posedge clk_i) disable iff (reset_i)
    out_valid_o && !out_ready_i |=> out_valid_o && $stable(out_data_o))
    else $error("delay stage output changed under back-pressure");

endmodule

// ==== logic/llc_isolate_stage.sv ====
// Isolate stage that tracks outstanding requests and terminates traffic when cut off
`timescale 1ns/1ns

module llc_isolate_stage
  import llc_cfg_pkg::*;
  import llc_txn_pkg::*;
(
  input  logic     clk_i,
  input  logic     reset_i,
  input  logic     isolate_i,
  output logic     isolated_o,
  // Requests from the delay stage
  input  logic     req_valid_i,
  output logic     req_ready_o,
  input  llc_req_t req_i,
  // Requests towards memory
  output logic     mem_req_valid_o,
  input  logic     mem_req_ready_i,
  output llc_req_t mem_req_o,
  // Responses from memory
  input  logic     mem_rsp_valid_i,
  output logic     mem_rsp_ready_o,
  input  llc_rsp_t mem_rsp_i,
  // Responses towards the delay stage
  output logic     rsp_valid_o,
  input  logic     rsp_ready_i,
  output llc_rsp_t rsp_o
);

  logic [CountWidth-1:0] out_cnt_q;
  logic                  isolated_q;
  logic                  hold_q;
  logic                  err_valid_q;
  logic [IdWidth-1:0]    err_id_q;
  logic                  fwd_en;
  logic                  mem_req_fire;
  logic                  mem_rsp_fire;
  logic                  err_fill;
  logic                  err_drain;
  llc_rsp_t              err_rsp;

  // New requests go to memory only in normal mode with room left
  assign fwd_en = !isolate_i && !isolated_q && !err_valid_q &&
                  (out_cnt_q != MaxOutstanding);

  // A request already offered to memory is kept until it transfers
  assign mem_req_valid_o = req_valid_i && (fwd_en || hold_q);
  assign mem_req_o       = req_i;
  assign mem_req_fire    = mem_req_valid_o && mem_req_ready_i;

  assign req_ready_o = isolated_q ? !err_valid_q : ((fwd_en || hold_q) && mem_req_ready_i);
  assign err_fill    = isolated_q && req_valid_i && !err_valid_q;

  // Terminated requests answer with an error and no data
  assign err_rsp.id    = err_id_q;
  assign err_rsp.rdata = '0;
  assign err_rsp.err   = 1'b1;

  // Memory responses win over the error slot
  assign mem_rsp_ready_o = rsp_ready_i;
  assign mem_rsp_fire    = mem_rsp_valid_i && rsp_ready_i;
  assign rsp_valid_o     = mem_rsp_valid_i || err_valid_q;
  assign rsp_o           = mem_rsp_valid_i ? mem_rsp_i : err_rsp;
  assign err_drain       = err_valid_q && !mem_rsp_valid_i && rsp_ready_i;

  assign isolated_o = isolated_q;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      out_cnt_q   <= '0;
      isolated_q  <= 1'b0;
      hold_q      <= 1'b0;
      err_valid_q <= 1'b0;
    end else begin
      hold_q <= mem_req_valid_o && !mem_req_ready_i;
      case ({mem_req_fire, mem_rsp_fire})
        2'b10:   out_cnt_q <= out_cnt_q + 1'b1;
        2'b01:   out_cnt_q <= out_cnt_q - 1'b1;
        default: out_cnt_q <= out_cnt_q;
      endcase
      // Cut off only after every forwarded request has been answered
      if (!isolate_i) begin
        isolated_q <= 1'b0;
      end else if ((out_cnt_q == '0) && !hold_q) begin
        isolated_q <= 1'b1;
      end
      if (err_fill) begin
        err_valid_q <= 1'b1;
      end else if (err_drain) begin
        err_valid_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (err_fill) begin
      err_id_q <= req_i.id;
    end
  end

  // Memory must not answer more requests than were sent to it
  assert property (@(posedge clk_i) disable iff (reset_i)
    (out_cnt_q == '0) |-> !(mem_rsp_fire && !mem_req_fire))
    else $error("outstanding counter underflow");

  assert property (@(posedge clk_i) disable iff (reset_i)
    isolated_o |-> !mem_req_valid_o)
    else $error("request reached memory while isolated");

endmodule

// ==== logic/llc_path.sv ====
// Top level of the LLC path chaining request delay, isolate and response delay
`timescale 1ns/1ns

module llc_path
  import llc_cfg_pkg::*;
  import llc_txn_pkg::*;
(
  input  logic                  clk_i,
  input  logic                  reset_i,
  // Upstream requests
  input  logic                  req_valid_i,
  output logic                  req_ready_o,
  input  logic [AddrWidth-1:0]  req_addr_i,
  input  logic                  req_we_i,
  input  logic [DataWidth-1:0]  req_wdata_i,
  input  logic [IdWidth-1:0]    req_id_i,
  // Upstream responses
  output logic                  rsp_valid_o,
  input  logic                  rsp_ready_i,
  output logic [IdWidth-1:0]    rsp_id_o,
  output logic [DataWidth-1:0]  rsp_rdata_o,
  output logic                  rsp_err_o,
  // Memory requests
  output logic                  mem_req_valid_o,
  input  logic                  mem_req_ready_i,
  output logic [AddrWidth-1:0]  mem_req_addr_o,
  output logic                  mem_req_we_o,
  output logic [DataWidth-1:0]  mem_req_wdata_o,
  output logic [IdWidth-1:0]    mem_req_id_o,
  // Memory responses
  input  logic                  mem_rsp_valid_i,
  output logic                  mem_rsp_ready_o,
  input  logic [IdWidth-1:0]    mem_rsp_id_i,
  input  logic [DataWidth-1:0]  mem_rsp_rdata_i,
  input  logic                  mem_rsp_err_i,
  // Delay and isolation control
  input  logic [DelayWidth-1:0] req_delay_i,
  input  logic [DelayWidth-1:0] rsp_delay_i,
  input  logic                  isolate_i,
  output logic                  isolated_o
);

  llc_req_t req_in;
  llc_req_t req_dly;
  logic     req_dly_valid;
  logic     req_dly_ready;
  llc_req_t mem_req;
  llc_rsp_t mem_rsp;
  llc_rsp_t rsp_iso;
  logic     rsp_iso_valid;
  logic     rsp_iso_ready;
  llc_rsp_t rsp_out;

  // Pack the upstream and memory-side ports into payloads
  assign req_in  = '{addr: req_addr_i, we: req_we_i, wdata: req_wdata_i, id: req_id_i};
  assign mem_rsp = '{id: mem_rsp_id_i, rdata: mem_rsp_rdata_i, err: mem_rsp_err_i};

  llc_delay_stage #(
    .payload_t   ( llc_req_t     )
  ) u_req_delay (
    .clk_i       ( clk_i         ),
    .reset_i     ( reset_i       ),
    .delay_i     ( req_delay_i   ),
    .in_valid_i  ( req_valid_i   ),
    .in_ready_o  ( req_ready_o   ),
    .in_data_i   ( req_in        ),
    .out_valid_o ( req_dly_valid ),
    .out_ready_i ( req_dly_ready ),
    .out_data_o  ( req_dly       )
  );

  llc_isolate_stage u_isolate (
    .clk_i           ( clk_i           ),
    .reset_i         ( reset_i         ),
    .isolate_i       ( isolate_i       ),
    .isolated_o      ( isolated_o      ),
    .req_valid_i     ( req_dly_valid   ),
    .req_ready_o     ( req_dly_ready   ),
    .req_i           ( req_dly         ),
    .mem_req_valid_o ( mem_req_valid_o ),
    .mem_req_ready_i ( mem_req_ready_i ),
    .mem_req_o       ( mem_req         ),
    .mem_rsp_valid_i ( mem_rsp_valid_i ),
    .mem_rsp_ready_o ( mem_rsp_ready_o ),
    .mem_rsp_i       ( mem_rsp         ),
    .rsp_valid_o     ( rsp_iso_valid   ),
    .rsp_ready_i     ( rsp_iso_ready   ),
    .rsp_o           ( rsp_iso         )
  );

  llc_delay_stage #(
    .payload_t   ( llc_rsp_t     )
  ) u_rsp_delay (
    .clk_i       ( clk_i         ),
    .reset_i     ( reset_i       ),
    .delay_i     ( rsp_delay_i   ),
    .in_valid_i  ( rsp_iso_valid ),
    .in_ready_o  ( rsp_iso_ready ),
    .in_data_i   ( rsp_iso       ),
    .out_valid_o ( rsp_valid_o   ),
    .out_ready_i ( rsp_ready_i   ),
    .out_data_o  ( rsp_out       )
  );

  // Unpack payloads back onto plain ports
  assign mem_req_addr_o  = mem_req.addr;
  assign mem_req_we_o    = mem_req.we;
  assign mem_req_wdata_o = mem_req.wdata;
  assign mem_req_id_o    = mem_req.id;
  assign rsp_id_o        = rsp_out.id;
  assign rsp_rdata_o     = rsp_out.rdata;
  assign rsp_err_o       = rsp_out.err;

endmodule

// ==== dv/llc_path_tb.sv ====
// Testbench for the LLC path with table-driven tests, in-order memory model, checks and run limit
`timescale 1ns/1ns

module llc_path_tb
  import llc_cfg_pkg::*;
();

  logic                  clk_i = 1'b0;
  logic                  reset_i, req_valid_i, req_ready_o, req_we_i;
  logic [AddrWidth-1:0]  req_addr_i, mem_req_addr_o;
  logic [DataWidth-1:0]  req_wdata_i, mem_req_wdata_o, rsp_rdata_o, mem_rsp_rdata_i;
  logic [IdWidth-1:0]    req_id_i, rsp_id_o, mem_req_id_o, mem_rsp_id_i;
  logic                  rsp_valid_o, rsp_ready_i, rsp_err_o;
  logic                  mem_req_valid_o, mem_req_ready_i, mem_req_we_o;
  logic                  mem_rsp_valid_i, mem_rsp_ready_o, mem_rsp_err_i;
  logic [DelayWidth-1:0] req_delay_i, rsp_delay_i;
  logic                  isolate_i, isolated_o;

  // Test table with one entry per data line
  string                t_name[$];
  string                t_op[$];
  logic [IdWidth-1:0]   t_id[$];
  logic [AddrWidth-1:0] t_addr[$];
  logic [DataWidth-1:0] t_wdata[$];
  logic [DataWidth-1:0] t_rdata[$];
  int                   t_rdly[$];
  int                   t_sdly[$];
  bit                   t_iso[$];
  bit                   t_err[$];

  // Memory model contents and its queue of pending answers
  logic [DataWidth-1:0] mem_model[logic [AddrWidth-1:0]];
  int                   due_q[$];
  logic [IdWidth-1:0]   rid_q[$];
  logic [DataWidth-1:0] rdata_q[$];

  logic [31:0] lcg_state = 32'h4aa0_dd93;
  int          cyc = 0;
  int          limit = 0;
  int          rsp_count = 0;
  int          leak_count = 0;
  int          issued = 0;
  int          pass_count = 0;
  int          fail_count = 0;

  llc_path uut (.*);

  always #2 clk_i = ~clk_i;

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  always @(posedge clk_i) begin
    cyc <= cyc + 1;
    if (limit != 0 && cyc > limit) begin
      $display("Run stopped at cycle %0d, past the limit of %0d cycles", cyc, limit);
      $display("test failed");
      $finish;
    end
  end

  // Ready about three cycles in four
  always @(posedge clk_i) begin
    lcg_state = lcg_next(lcg_state);
    rsp_ready_i <= reset_i ? 1'b0 : (lcg_state[31:30] != 2'b00);
  end

  // Memory answers in order two cycles after taking a request
  always @(posedge clk_i) begin
    if (reset_i) begin
      mem_rsp_valid_i <= 1'b0;
    end else begin
      if (mem_rsp_valid_i && mem_rsp_ready_o) begin
        due_q.delete(0);
        rid_q.delete(0);
        rdata_q.delete(0);
      end
      if (mem_req_valid_o && mem_req_ready_i) begin
        due_q.push_back(cyc + 1);
        rid_q.push_back(mem_req_id_o);
        if (mem_req_we_o) begin
          rdata_q.push_back('0);
          mem_model[mem_req_addr_o] = mem_req_wdata_o;
        end else begin
          rdata_q.push_back(mem_model.exists(mem_req_addr_o) ? mem_model[mem_req_addr_o] : '0);
        end
      end
      mem_rsp_valid_i <= 1'b0;
      if (due_q.size() != 0) begin
        mem_rsp_valid_i <= (due_q[0] <= cyc);
        mem_rsp_id_i    <= rid_q[0];
        mem_rsp_rdata_i <= rdata_q[0];
      end
    end
  end

  always @(posedge clk_i) begin
    if (!reset_i && rsp_valid_o && rsp_ready_i) begin
      rsp_count <= rsp_count + 1;
    end
    if (!reset_i && isolated_o && mem_req_valid_o) begin
      $display("A request reached memory while the path was isolated");
      leak_count <= leak_count + 1;
    end
  end

  task automatic load_tests();
    int          fd;
    int          n;
    string       line;
    string       name;
    string       op;
    logic [31:0] id, addr, wdata, exp_rdata;
    int          rdly, sdly, iso, exp_err;
    fd = $fopen("dv/llc_path_tests.txt", "r");
    if (fd == 0) begin
      $display("Cannot open the test table dv/llc_path_tests.txt");
      fail_count++;
    end else begin
      limit = 50;
      while (!$feof(fd)) begin
        line = "";
        n = $fgets(line, fd);
        if (line.len() < 2 || line[0] == "#") begin
          continue;
        end
        n = $sscanf(line, "%s %s %h %h %h %d %d %d %h %d", name, op, id, addr, wdata,
                    rdly, sdly, iso, exp_rdata, exp_err);
        if (n != 10) begin
          continue;
        end
        t_name.push_back(name);
        t_op.push_back(op);
        t_id.push_back(id[IdWidth-1:0]);
        t_addr.push_back(addr);
        t_wdata.push_back(wdata);
        t_rdly.push_back(rdly);
        t_sdly.push_back(sdly);
        t_iso.push_back(iso != 0);
        t_rdata.push_back(exp_rdata);
        t_err.push_back(exp_err != 0);
        limit += rdly + sdly + 40;
      end
      $fclose(fd);
    end
  endtask

  // One request followed by a check of its response
  task automatic issue_and_check(input int k, output bit ok);
    int t_acc;
    int waited;
    bit got;
    ok          = 1'b1;
    got         = 1'b0;
    waited      = 0;
    isolate_i   <= t_iso[k];
    req_delay_i <= DelayWidth'(t_rdly[k]);
    rsp_delay_i <= DelayWidth'(t_sdly[k]);
    req_valid_i <= 1'b1;
    req_we_i    <= (t_op[k] == "write");
    req_addr_i  <= t_addr[k];
    req_wdata_i <= t_wdata[k];
    req_id_i    <= t_id[k];
    @(posedge clk_i);
    while (!req_ready_o) @(posedge clk_i);
    t_acc = cyc;
    issued++;
    req_valid_i <= 1'b0;
    while (!got && waited < t_rdly[k] + t_sdly[k] + 40) begin
      @(posedge clk_i);
      waited++;
      got = rsp_valid_o && rsp_ready_i;
    end
    if (!got) begin
      $display("No response arrived for test %s", t_name[k]);
      ok = 1'b0;
    end else begin
      if (rsp_id_o !== t_id[k]) begin
        $display("MISMATCH %s id expected %h actual %h", t_name[k], t_id[k], rsp_id_o);
        ok = 1'b0;
      end
      if (rsp_rdata_o !== t_rdata[k]) begin
        $display("MISMATCH %s rdata expected %h actual %h", t_name[k], t_rdata[k], rsp_rdata_o);
        ok = 1'b0;
      end
      if (rsp_err_o !== t_err[k]) begin
        $display("MISMATCH %s err expected %0d actual %0d", t_name[k], t_err[k], rsp_err_o);
        ok = 1'b0;
      end
      // Memory latency of 2 on top of both delays and their one-cycle entry
      if (!t_err[k] && (cyc - t_acc) < t_rdly[k] + t_sdly[k] + 4) begin
        $display("Response for test %s came %0d cycles after acceptance, minimum is %0d",
                 t_name[k], cyc - t_acc, t_rdly[k] + t_sdly[k] + 4);
        ok = 1'b0;
      end
    end
  endtask

  task automatic switch_isolation(input int k, output bit ok);
    int waited;
    ok        = 1'b1;
    waited    = 0;
    isolate_i <= t_iso[k];
    do begin
      @(posedge clk_i);
      waited++;
    end while (isolated_o !== t_iso[k] && waited < 40);
    if (isolated_o !== t_iso[k]) begin
      $display("isolated_o did not reach %0d within 40 cycles in test %s", t_iso[k], t_name[k]);
      ok = 1'b0;
    end
  endtask

  initial begin
    bit ok;
    reset_i         = 1'b1;
    req_valid_i     = 1'b0;
    req_we_i        = 1'b0;
    req_addr_i      = '0;
    req_wdata_i     = '0;
    req_id_i        = '0;
    rsp_ready_i     = 1'b0;
    mem_req_ready_i = 1'b1;
    mem_rsp_valid_i = 1'b0;
    mem_rsp_id_i    = '0;
    mem_rsp_rdata_i = '0;
    mem_rsp_err_i   = 1'b0;
    req_delay_i     = '0;
    rsp_delay_i     = '0;
    isolate_i       = 1'b0;
    load_tests();
    repeat (5) @(posedge clk_i);
    reset_i <= 1'b0;
    foreach (t_name[k]) begin
      if (t_op[k] == "isolate") begin
        switch_isolation(k, ok);
      end else begin
        issue_and_check(k, ok);
      end
      if (ok) begin
        pass_count++;
        $display("PASS %s", t_name[k]);
      end else begin
        fail_count++;
        $display("FAIL %s", t_name[k]);
      end
    end
    // Room for any stray response to show up
    repeat (20) @(posedge clk_i);
    if (rsp_count != issued) begin
      $display("Got %0d responses for %0d requests", rsp_count, issued);
    end
    $display("Tests run %0d, pass count %0d, fail count %0d", t_name.size(), pass_count,
             fail_count);
    if (fail_count == 0 && leak_count == 0 && rsp_count == issued) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule

// ==== llc_path.f ====
logic/llc_cfg_pkg.sv
logic/llc_txn_pkg.sv
logic/llc_delay_stage.sv
logic/llc_isolate_stage.sv
logic/llc_path.sv
dv/llc_path_tb.sv

// ==== Bender.yml ====
package:
  name: llc_path

sources:
  - logic/llc_cfg_pkg.sv
  - logic/llc_txn_pkg.sv
  - logic/llc_delay_stage.sv
  - logic/llc_isolate_stage.sv
  - logic/llc_path.sv
  - target: test
    files:
      - dv/llc_path_tb.sv

// ==== dv/llc_path_tests.txt ====
# name op id addr wdata req_delay rsp_delay isolate exp_rdata exp_err
# id, addr, wdata and exp_rdata in hex; delays, isolate and exp_err in decimal
wr_a0     write   1 00000010 deadbeef   0   0 0 00000000 0
rd_a0     read    2 00000010 00000000   0   0 0 deadbeef 0
wr_a1     write   3 00000024 12345678   5   3 0 00000000 0
rd_a1     read    4 00000024 00000000   3   5 0 12345678 0
wr_a2     write   5 00000100 a5a55a5a  20   0 0 00000000 0
rd_a2     read    6 00000100 00000000   0  20 0 a5a55a5a 0
rd_unwr   read    7 00000200 00000000   1   1 0 00000000 0
wr_a3     write   8 ffff0000 0badf00d 255 255 0 00000000 0
rd_a3     read    9 ffff0000 00000000  12   7 0 0badf00d 0
wr_a0b    write   a 00000010 cafef00d   2   2 0 00000000 0
iso_on    isolate 0 00000000 00000000   0   0 1 00000000 0
rd_iso    read    b 00000010 00000000   3   2 1 00000000 1
wr_iso    write   c 00000024 ffffffff   0   0 1 00000000 1
rd_iso2   read    d 00000100 00000000   6   4 1 00000000 1
iso_off   isolate 0 00000000 00000000   0   0 0 00000000 0
rd_a0c    read    e 00000010 00000000   1   2 0 cafef00d 0
rd_a1b    read    f 00000024 00000000   0   3 0 12345678 0
rd_a2b    read    0 00000100 00000000   8   8 0 a5a55a5a 0
wr_a4     write   1 0000abcd 11112222   4   9 0 00000000 0
rd_a4     read    2 0000abcd 00000000   9   4 0 11112222 0
wr_a5     write   3 00000040 00c0ffee   0   1 0 00000000 0
rd_a5     read    4 00000040 00000000  30   0 0 00c0ffee 0
